//--- dataMem.f
+incdir+hdl
hdl/dataMemPkg.sv
hdl/storeLaneSteer.sv
hdl/byteLaneRam.sv
hdl/loadExtract.sv
hdl/rspQueue.sv
hdl/creditLedger.sv
hdl/dataMemTop.sv
verification/dataMemTb.sv

//--- hdl/byteLaneRam.sv
`timescale 1ns/1ps
`include "dataMemDefs.svh"

module byteLaneRam (
    input  logic                      CLK,
    input  logic [`LANE_COUNT-1:0]    stByteEn,
    input  logic [`MEM_WORD_BITS-1:0] stWordIdx,
    input  dataMemPkg::memWord_u      stData,
    output logic [`DATA_WIDTH-1:0]    rdWord
);

    //////////////////////////////////////////////////
    // One byte-wide bank per lane
    //////////////////////////////////////////////////
    for (genvar lane = 0; lane < `LANE_COUNT; lane++) begin : gLane
        logic [7:0] bank [`MEM_WORDS];   // Lane storage
        logic [7:0] rdByte;              // Registered read of this lane

        always_ff @(posedge CLK) begin
            if (stByteEn[lane]) begin
                bank[stWordIdx] <= stData.bytes[lane];   // Own lane enable
            end
            // Old data on a same-edge write; next access sees the new byte
            rdByte <= bank[stWordIdx];
        end

        assign rdWord[lane*8 +: 8] = rdByte;   // Reassemble the word
    end

endmodule

//--- hdl/creditLedger.sv
`timescale 1ns/1ps
`include "dataMemDefs.svh"

module creditLedger (
    input  logic CLK,
    input  logic rst,
    input  logic storeCommit,
    input  logic popFire,
    output logic creditReturn
);

    localparam int cntBits = $clog2(`CREDIT_COUNT + 1);

    logic [cntBits-1:0] owed;       // Credits not yet handed back
    logic [cntBits:0]   owedNext;   // One bit spare to catch overflow

    // One pulse per cycle while anything is owed
    assign creditReturn = owed != '0;

    // Up to two earned per cycle, one paid
    assign owedNext = (cntBits+1)'(owed) + storeCommit + popFire - creditReturn;

    //////////////////////////////////////////////////
    // Owed credit counter
    //////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (rst) begin
            owed <= '0;
        end else begin
            owed <= owedNext[cntBits-1:0];
        end
    end

    // Requester limit bounds what the memory can owe
    owedBound: assert property (@(posedge CLK) disable iff (rst)
        owedNext <= (cntBits+1)'(`CREDIT_COUNT));

endmodule

//--- hdl/dataMemDefs.svh
`ifndef DATA_MEM_DEFS_SVH
`define DATA_MEM_DEFS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////
`define DATA_WIDTH    32              // Memory word and load result
`define ADDR_WIDTH    32              // Byte address from the core
`define LANE_COUNT    4               // Byte lanes per word

//////////////////////////////////////////////////
// Memory window
//////////////////////////////////////////////////
`define MEM_WORD_BITS 8               // Word index width, 256 words
`define MEM_WORDS     (1 << `MEM_WORD_BITS)
`define MEM_BYTES     (`MEM_WORDS * `LANE_COUNT)   // Window size in bytes, 1 KiB
`define MEM_BASE_ADDR 32'h0000_1000   // First byte of the window

// Requests in flight, also the response FIFO depth
`define CREDIT_COUNT  4

`endif

//--- hdl/dataMemPkg.sv
`include "dataMemDefs.svh"

package dataMemPkg;

    // One memory word seen two ways
    // Stores place data into a lane, loads pick a lane out
    typedef union packed {
        logic [`LANE_COUNT-1:0][7:0]       bytes;   // Lane 0 is the LSB
        logic [1:0][`DATA_WIDTH/2-1:0]     halves;  // Half 1 is bits 31:16
    } memWord_u;

endpackage

//--- hdl/dataMemTop.sv
`timescale 1ns/1ps
`include "dataMemDefs.svh"

module dataMemTop (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   reqValid,
    input  logic                   reqWrite,
    input  logic [2:0]             reqFunct3,
    input  logic [`ADDR_WIDTH-1:0] reqAddr,
    input  logic [`DATA_WIDTH-1:0] reqWdata,
    input  logic                   rspReady,
    output logic                   rspValid,
    output logic [`DATA_WIDTH-1:0] rspData,
    output logic                   creditReturn
);

    // Stage 1 request fields
    logic                      stValid;
    logic                      stWrite;
    logic                      stInWindow;
    logic [`MEM_WORD_BITS-1:0] stWordIdx;
    logic [`LANE_COUNT-1:0]    stByteEn;
    dataMemPkg::memWord_u      stData;
    logic [1:0]                stSize;
    logic                      stUnsigned;
    logic [1:0]                stLaneSel;
    logic                      storeCommit;

    logic [`DATA_WIDTH-1:0]    rdWord;      // RAM read, stage 2
    logic                      pushValid;   // Load result into FIFO
    logic [`DATA_WIDTH-1:0]    pushData;
    logic                      popFire;     // Response taken

    //////////////////////////////////////////////////
    // Pipeline
    //////////////////////////////////////////////////
    storeLaneSteer storeLaneSteer_i (
        .CLK(CLK), .rst(rst),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqFunct3(reqFunct3),
        .reqAddr(reqAddr), .reqWdata(reqWdata),
        .stValid(stValid), .stWrite(stWrite), .stInWindow(stInWindow),
        .stWordIdx(stWordIdx), .stByteEn(stByteEn), .stData(stData),
        .stSize(stSize), .stUnsigned(stUnsigned), .stLaneSel(stLaneSel),
        .storeCommit(storeCommit)
    );

    byteLaneRam byteLaneRam_i (
        .CLK(CLK), .stByteEn(stByteEn), .stWordIdx(stWordIdx),
        .stData(stData), .rdWord(rdWord)
    );

    loadExtract loadExtract_i (
        .CLK(CLK), .rst(rst),
        .stValid(stValid), .stWrite(stWrite), .stInWindow(stInWindow),
        .stSize(stSize), .stUnsigned(stUnsigned), .stLaneSel(stLaneSel),
        .rdWord(rdWord), .pushValid(pushValid), .pushData(pushData)
    );

    // Responses out, credits back
    rspQueue rspQueue_i (
        .CLK(CLK), .rst(rst), .pushValid(pushValid), .pushData(pushData),
        .rspReady(rspReady), .rspValid(rspValid), .rspData(rspData), .popFire(popFire)
    );

    creditLedger creditLedger_i (
        .CLK(CLK), .rst(rst), .storeCommit(storeCommit),
        .popFire(popFire), .creditReturn(creditReturn)
    );

endmodule

//--- hdl/loadExtract.sv
`timescale 1ns/1ps
`include "dataMemDefs.svh"

module loadExtract (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   stValid,
    input  logic                   stWrite,
    input  logic                   stInWindow,
    input  logic [1:0]             stSize,
    input  logic                   stUnsigned,
    input  logic [1:0]             stLaneSel,
    input  logic [`DATA_WIDTH-1:0] rdWord,
    output logic                   pushValid,
    output logic [`DATA_WIDTH-1:0] pushData
);

    // Load control, one cycle behind to line up with rdWord
    logic       ldValid;
    logic       ldInWindow;
    logic [1:0] ldSize;
    logic       ldUnsigned;
    logic [1:0] ldLaneSel;

    dataMemPkg::memWord_u     word;
    logic [7:0]               selByte;
    logic [`DATA_WIDTH/2-1:0] selHalf;
    logic [`DATA_WIDTH-1:0]   extData;

    always_ff @(posedge CLK) begin
        if (rst) begin
            ldValid <= 1'b0;
        end else begin
            ldValid <= stValid & ~stWrite;   // Only loads answer
        end
    end

    always_ff @(posedge CLK) begin
        ldInWindow <= stInWindow;
        ldSize     <= stSize;
        ldUnsigned <= stUnsigned;
        ldLaneSel  <= stLaneSel;
    end

    //////////////////////////////////////////////////
    // Lane select and extension
    //////////////////////////////////////////////////
    assign word    = rdWord;
    assign selByte = word.bytes[ldLaneSel];        // Byte by bits 1:0
    assign selHalf = word.halves[ldLaneSel[1]];    // Half by bit 1

    always_comb begin
        case (ldSize)
            2'b00: extData = {{(`DATA_WIDTH-8){~ldUnsigned & selByte[7]}}, selByte};
            2'b01: extData = {{(`DATA_WIDTH/2){~ldUnsigned & selHalf[`DATA_WIDTH/2-1]}},
                              selHalf};
            2'b10: extData = word;            // LW as is
            default: extData = '0;            // Size 11 unsupported
        endcase
        if (!ldInWindow) begin
            extData = '0;                     // Outside the window reads zero
        end
    end

    // Stage 2 result toward the response FIFO
    always_ff @(posedge CLK) begin
        if (rst) begin
            pushValid <= 1'b0;
        end else begin
            pushValid <= ldValid;
        end
    end

    always_ff @(posedge CLK) begin
        pushData <= extData;
    end

endmodule

//--- hdl/rspQueue.sv
`timescale 1ns/1ps
`include "dataMemDefs.svh"

module rspQueue (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   pushValid,
    input  logic [`DATA_WIDTH-1:0] pushData,
    input  logic                   rspReady,
    output logic                   rspValid,
    output logic [`DATA_WIDTH-1:0] rspData,
    output logic                   popFire
);

    localparam int ptrBits = $clog2(`CREDIT_COUNT);       // Slot index width
    localparam int cntBits = $clog2(`CREDIT_COUNT + 1);   // Holds 0 to full

    logic [`DATA_WIDTH-1:0] slots [`CREDIT_COUNT];   // Circular storage
    logic [ptrBits-1:0]     wrPtr;
    logic [ptrBits-1:0]     rdPtr;
    logic [cntBits-1:0]     count;                   // Occupancy
    logic                   full;

    assign full     = count == cntBits'(`CREDIT_COUNT);
    assign rspValid = count != '0;
    assign rspData  = slots[rdPtr];        // Head of the FIFO
    assign popFire  = rspValid & rspReady;  // Transfer this edge

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= (wrPtr == ptrBits'(`CREDIT_COUNT - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popFire) begin
                rdPtr <= (rdPtr == ptrBits'(`CREDIT_COUNT - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({pushValid, popFire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;     // Both or neither
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (pushValid) begin
            slots[wrPtr] <= pushData;
        end
    end

    // Credit limit upstream keeps loads in flight within the depth
    noPushFull: assert property (@(posedge CLK) disable iff (rst)
        full |-> !pushValid);

endmodule

//--- hdl/storeLaneSteer.sv
`timescale 1ns/1ps
`include "dataMemDefs.svh"

module storeLaneSteer (
    input  logic                      CLK,
    input  logic                      rst,
    input  logic                      reqValid,
    input  logic                      reqWrite,
    input  logic [2:0]                reqFunct3,
    input  logic [`ADDR_WIDTH-1:0]    reqAddr,
    input  logic [`DATA_WIDTH-1:0]    reqWdata,
    output logic                      stValid,
    output logic                      stWrite,
    output logic                      stInWindow,
    output logic [`MEM_WORD_BITS-1:0] stWordIdx,
    output logic [`LANE_COUNT-1:0]    stByteEn,
    output dataMemPkg::memWord_u      stData,
    output logic [1:0]                stSize,
    output logic                      stUnsigned,
    output logic [1:0]                stLaneSel,
    output logic                      storeCommit
);

    logic [`ADDR_WIDTH-1:0] offset;     // Address relative to the window base
    logic                   inWindow;
    logic [`LANE_COUNT-1:0] byteEn;
    dataMemPkg::memWord_u   laneData;   // Write data moved to its lane

    assign offset   = reqAddr - `MEM_BASE_ADDR;   // Below the base wraps high, so out
    assign inWindow = offset < `MEM_BYTES;

    //////////////////////////////////////////////////
    // Lane enables from size and low address bits
    //////////////////////////////////////////////////
    always_comb begin
        byteEn = '0;
        case (reqFunct3[1:0])
            2'b00: byteEn[reqAddr[1:0]] = 1'b1;                    // SB
            2'b01: byteEn = reqAddr[1] ? 4'b1100 : 4'b0011;       // SH, bit 1 picks half
            2'b10: byteEn = '1;                                    // SW
            default: byteEn = '0;                                  // Size 11 writes nothing
        endcase
        if (!(reqValid && reqWrite && inWindow)) begin
            byteEn = '0;   // Loads and stray stores touch no lane
        end
    end

    // Shift write data into the addressed byte or half
    always_comb begin
        laneData = '0;
        case (reqFunct3[1:0])
            2'b00: laneData.bytes[reqAddr[1:0]] = reqWdata[7:0];
            2'b01: laneData.halves[reqAddr[1]]  = reqWdata[`DATA_WIDTH/2-1:0];
            2'b10: laneData = reqWdata;
            default: laneData = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Stage 1 registers
    //////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (rst) begin
            stValid  <= 1'b0;
            stWrite  <= 1'b0;
            stByteEn <= '0;
        end else begin
            stValid  <= reqValid;
            stWrite  <= reqWrite;
            stByteEn <= byteEn;
        end
    end

    always_ff @(posedge CLK) begin
        stInWindow <= inWindow;
        stWordIdx  <= offset[`MEM_WORD_BITS+1:2];   // Drop the byte offset
        stData     <= laneData;
        stSize     <= reqFunct3[1:0];
        stUnsigned <= reqFunct3[2];                 // LBU / LHU
        stLaneSel  <= reqAddr[1:0];
    end

    // Every store gives its credit back, even one that wrote nothing
    assign storeCommit = stValid & stWrite;

    // RAM lanes stay idle in bubble cycles
    byteEnIdle: assert property (@(posedge CLK) disable iff (rst)
        !stValid |-> stByteEn == '0);

endmodule

//--- verification/dataMemTb.sv
`timescale 1ns/1ps
`include "dataMemDefs.svh"

module dataMemTb;

    localparam int rowCount   = 32;    // Table rows below
    localparam int stallLimit = 100;   // Cycles to wait for one credit
    localparam int drainLimit = 100;   // Cycles to wait for a test to settle

    logic                   CLK;
    logic                   rst;
    logic                   reqValid;
    logic                   reqWrite;
    logic [2:0]             reqFunct3;
    logic [`ADDR_WIDTH-1:0] reqAddr;
    logic [`DATA_WIDTH-1:0] reqWdata;
    logic                   rspReady;
    logic                   rspValid;
    logic [`DATA_WIDTH-1:0] rspData;
    logic                   creditReturn;

    // Stimulus table, one request per row
    int                     rowTest   [rowCount];
    logic                   rowWrite  [rowCount];
    logic [2:0]             rowFunct3 [rowCount];
    logic [`ADDR_WIDTH-1:0] rowAddr   [rowCount];
    logic [`DATA_WIDTH-1:0] rowWdata  [rowCount];
    logic [`DATA_WIDTH-1:0] rowExpect [rowCount];
    int                     rowFill = 0;

    logic [`DATA_WIDTH-1:0] expQ [$];              // Load results still owed, in order
    int                     credits = `CREDIT_COUNT;
    int                     errors = 0;
    int                     testsOk = 0;
    int                     testsBad = 0;
    logic [31:0]            lfsr = 32'hb3712edb;   // Back-pressure source

    dataMemTop dataMemTop_i (
        .CLK(CLK), .rst(rst),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqFunct3(reqFunct3),
        .reqAddr(reqAddr), .reqWdata(reqWdata),
        .rspReady(rspReady), .rspValid(rspValid), .rspData(rspData),
        .creditReturn(creditReturn)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;   // 8 ns period
    end

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        lfsrStep = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic addRow(input int t, input logic wr, input logic [2:0] f3,
                          input logic [31:0] addr, input logic [31:0] wd,
                          input logic [31:0] ex);
        rowTest[rowFill]   = t;
        rowWrite[rowFill]  = wr;
        rowFunct3[rowFill] = f3;
        rowAddr[rowFill]   = addr;
        rowWdata[rowFill]  = wd;
        rowExpect[rowFill] = ex;
        rowFill++;
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////
    task automatic buildTable();
        // Test 1, SW then LW at both ends of the window
        addRow(1, 1, 3'b010, 32'h1000, 32'hdeadbeef, 0);
        addRow(1, 0, 3'b010, 32'h1000, 0, 32'hdeadbeef);
        addRow(1, 1, 3'b010, 32'h13fc, 32'h12345678, 0);
        addRow(1, 0, 3'b010, 32'h13fc, 0, 32'h12345678);
        // Test 2, byte and half merges into one word
        addRow(2, 1, 3'b010, 32'h1010, 32'h11223344, 0);
        addRow(2, 1, 3'b000, 32'h1011, 32'h000000a5, 0);   // Lane 1
        addRow(2, 1, 3'b001, 32'h1012, 32'h0000beef, 0);   // Upper half
        addRow(2, 1, 3'b000, 32'h1010, 32'hffffff7f, 0);   // Lane 0, upper bits ignored
        addRow(2, 0, 3'b010, 32'h1010, 0, 32'hbeefa57f);
        // Test 3, narrow loads with sign and zero extension
        addRow(3, 1, 3'b010, 32'h1020, 32'h80f17e93, 0);
        addRow(3, 0, 3'b000, 32'h1020, 0, 32'hffffff93);
        addRow(3, 0, 3'b100, 32'h1021, 0, 32'h0000007e);
        addRow(3, 0, 3'b000, 32'h1022, 0, 32'hfffffff1);
        addRow(3, 0, 3'b100, 32'h1023, 0, 32'h00000080);
        addRow(3, 0, 3'b000, 32'h1023, 0, 32'hffffff80);
        addRow(3, 0, 3'b001, 32'h1020, 0, 32'h00007e93);
        addRow(3, 0, 3'b101, 32'h1022, 0, 32'h000080f1);
        addRow(3, 0, 3'b001, 32'h1022, 0, 32'hffff80f1);
        // Test 4, window edges and size 11
        addRow(4, 1, 3'b010, 32'h0ffc, 32'hcafef00d, 0);   // Just below base
        addRow(4, 1, 3'b010, 32'h1400, 32'hcafef00d, 0);   // Just past the end
        addRow(4, 1, 3'b011, 32'h1000, 32'hffffffff, 0);
        addRow(4, 0, 3'b010, 32'h1000, 0, 32'hdeadbeef);
        addRow(4, 0, 3'b010, 32'h13fc, 0, 32'h12345678);
        addRow(4, 0, 3'b010, 32'h1400, 0, 32'h00000000);
        addRow(4, 0, 3'b000, 32'h0ffc, 0, 32'h00000000);
        addRow(4, 0, 3'b011, 32'h1020, 0, 32'h00000000);
        // Test 5, back-to-back mix under back-pressure
        addRow(5, 0, 3'b010, 32'h1010, 0, 32'hbeefa57f);
        addRow(5, 0, 3'b100, 32'h1023, 0, 32'h00000080);
        addRow(5, 1, 3'b010, 32'h1030, 32'h0badcafe, 0);
        addRow(5, 0, 3'b010, 32'h1030, 0, 32'h0badcafe);
        addRow(5, 0, 3'b101, 32'h1032, 0, 32'h00000bad);
        addRow(5, 0, 3'b000, 32'h1031, 0, 32'hffffffca);
    endtask

    // Falling edge, drop the request and collect a returned credit
    task automatic nextCycle();
        @(negedge CLK);
        reqValid = 1'b0;
        if (creditReturn) begin
            credits++;
            if (credits > `CREDIT_COUNT) begin
                $display("Credit returned at %0t ns with nothing outstanding", $time);
                errors++;
            end
        end
    endtask

    task automatic issueRow(input int i);
        int waited;
        waited = 0;
        nextCycle();
        while (credits == 0 && waited < stallLimit) begin   // Stall until a credit is back
            nextCycle();
            waited++;
        end
        if (credits == 0) begin
            $display("Row %0d never got a credit to issue with", i);
            errors++;
        end else begin
            credits--;
            reqValid  = 1'b1;
            reqWrite  = rowWrite[i];
            reqFunct3 = rowFunct3[i];
            reqAddr   = rowAddr[i];
            reqWdata  = rowWdata[i];
            if (!rowWrite[i]) begin
                expQ.push_back(rowExpect[i]);
            end
        end
    endtask

    // Wait for all responses and all credits of one test
    task automatic finishTest(input int t, input int errBefore);
        int waited;
        waited = 0;
        while ((expQ.size() != 0 || credits != `CREDIT_COUNT) && waited < drainLimit) begin
            nextCycle();
            waited++;
        end
        if (expQ.size() != 0) begin
            $display("Test %0d: %0d load responses never arrived", t, expQ.size());
            errors++;
        end else if (credits != `CREDIT_COUNT) begin
            $display("Test %0d: only %0d of %0d credits came back", t, credits, `CREDIT_COUNT);
            errors++;
        end
        repeat (4) nextCycle();   // Catch stray extra credits
        if (errors == errBefore) begin
            testsOk++;
            $display("Test %0d done, ok", t);
        end else begin
            testsBad++;
            $display("Test %0d done, %0d errors", t, errors - errBefore);
        end
    endtask

    //////////////////////////////////////////////////
    // Response monitor and random ready
    //////////////////////////////////////////////////
    always @(negedge CLK) begin : respMonitor
        logic [`DATA_WIDTH-1:0] expVal;
        lfsr     = lfsrStep(lfsr);   // One step, one bit
        rspReady = lfsr[0];
        if (rspValid && rspReady) begin   // Transfers at the coming rising edge
            if (expQ.size() == 0) begin
                $display("Response %h at %0t ns with no load pending", rspData, $time);
                errors++;
            end else begin
                expVal = expQ.pop_front();
                if (rspData !== expVal) begin
                    $display("Error at %0t ns: load expected %h, got %h", $time, expVal, rspData);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(rowCount * 40 * 8);
        $display("Timeout after %0d ns, run did not finish", rowCount * 40 * 8);
        $display("Test failed");
        $finish;
    end

    initial begin : mainFlow
        int errBefore;
        rst       = 1'b1;
        reqValid  = 1'b0;
        reqWrite  = 1'b0;
        reqFunct3 = '0;
        reqAddr   = '0;
        reqWdata  = '0;
        rspReady  = 1'b0;
        buildTable();
        if (rowFill != rowCount) begin
            $display("Table holds %0d rows instead of %0d", rowFill, rowCount);
            errors++;
        end
        repeat (5) @(posedge CLK);   // Reset for 5 cycles
        @(negedge CLK);
        rst = 1'b0;
        errBefore = errors;
        for (int i = 0; i < rowCount; i++) begin
            issueRow(i);
            if (i == rowCount - 1 || rowTest[i+1] != rowTest[i]) begin   // Last row of a test
                finishTest(rowTest[i], errBefore);
                errBefore = errors;
            end
        end
        $display("Summary: %0d tests ok, %0d with errors, %0d errors in all",
                 testsOk, testsBad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
